// ==== hw/mesh_cfg_pkg.sv ====
`default_nettype none

package mesh_cfg_pkg;

   // basic widths
   localparam int PACKET_W  = 104;
   localparam int ADDR_W    = 32;
   localparam int WORD_W    = 32;
   localparam int MI_ADDR_W = 15;
   localparam int MI_DATA_W = 64;

   // packet field positions with the low bit first
   localparam int WRITE_BIT     = 0;
   localparam int DATAMODE_LSB  = 1;
   localparam int DATAMODE_W    = 2;
   localparam int CTRLMODE_LSB  = 3;
   localparam int CTRLMODE_W    = 4;
   localparam int RSVD_BIT      = 7;
   localparam int DSTADDR_LSB   = 8;
   localparam int DATA_LSB      = 40;
   localparam int SRCADDR_LSB   = 72;

   // address map inside dstaddr
   localparam int CHIP_LSB      = 20;
   localparam int GROUP_LSB     = 16;
   localparam int CFG_SUB_LSB   = 9;
   localparam int CFG_SIDE_BIT  = 8;
   localparam int DMA_SUB_LSB   = 8;
   localparam int DMA_SIDE_BIT  = 5;
   localparam int MMU_SIDE_BIT  = 15;

   localparam logic [11:0] CHIP_ID      = 12'h810;
   localparam logic [3:0]  GROUP_CFG    = 4'hF;
   localparam logic [3:0]  GROUP_MMU    = 4'hE;
   localparam logic [1:0]  CFG_SUBGROUP = 2'b01;
   localparam logic [2:0]  DMA_SUBGROUP = 3'h5;

   // register indexing
   localparam int NUM_CFG_REGS    = 8;
   localparam int NUM_DMA_REGS    = 8;
   localparam int NUM_MMU_ENTRIES = 16;
   localparam int REG_IDX_LSB     = 2;
   localparam int REG_IDX_W       = 3;
   localparam int MMU_IDX_LSB     = 3;
   localparam int MMU_IDX_W       = 4;

   typedef logic [PACKET_W-1:0]  packet_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [MI_ADDR_W-1:0] mi_addr_t;
   typedef logic [MI_DATA_W-1:0] mi_data_t;
   typedef logic [DATAMODE_W-1:0] datamode_t;
   typedef logic [CTRLMODE_W-1:0] ctrlmode_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [MMU_IDX_W-1:0] mmu_idx_t;

   // config block defaults with index 0 first
   localparam word_t CFG_RESET_VALUES [NUM_CFG_REGS] = '{
      32'h0000_0000,
      32'h0000_0001,
      32'h0000_0810,
      32'h0000_0000,
      32'h0001_0000,
      32'h0000_00FF,
      32'h0000_0000,
      32'hC0DE_0001
   };

   // read-only dma status slot
   localparam reg_idx_t DMA_STATUS_IDX  = 3'd7;
   localparam word_t    DMA_STATUS_WORD = 32'h0000_0A5A;

endpackage

`default_nettype wire

// ==== hw/mi_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mi_bus_if;
   import mesh_cfg_pkg::*;

   // single-cycle access, no handshake
   logic     en;
   logic     we;
   mi_addr_t addr;
   mi_data_t din;
   // zero unless this block is being read
   mi_data_t dout;

   modport decoder (
      output en,
      output we,
      output addr,
      output din,
      input  dout
   );

   modport block (
      input  en,
      input  we,
      input  addr,
      input  din,
      output dout
   );

endinterface

`default_nettype wire

// ==== hw/cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module cfg_regs (
   input  wire logic clk,
   input  wire logic rst_n,
   mi_bus_if.block   bus
);
   import mesh_cfg_pkg::*;

   word_t    regs [NUM_CFG_REGS];
   reg_idx_t idx;
   logic     wr_en;
   logic     rd_en;

   // word index from address bits 4:2
   assign idx   = bus.addr[REG_IDX_LSB +: REG_IDX_W];
   assign wr_en = bus.en && bus.we;
   assign rd_en = bus.en && !bus.we;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_CFG_REGS; i++)
         begin
            regs[i] <= CFG_RESET_VALUES[i];
         end
      end
      else if (wr_en)
      begin
         // only the data half lands here
         regs[idx] <= bus.din[WORD_W-1:0];
      end
   end

   // upper half always zero for this block
   assign bus.dout = rd_en ? {{(MI_DATA_W-WORD_W){1'b0}}, regs[idx]} : '0;

   // decoder relies on idle blocks reading zero
   a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !bus.en |-> (bus.dout == '0));

endmodule

`default_nettype wire

// ==== hw/dma_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_regs (
   input  wire logic clk,
   input  wire logic rst_n,
   mi_bus_if.block   bus
);
   import mesh_cfg_pkg::*;

   word_t    regs [NUM_DMA_REGS];
   reg_idx_t idx;
   logic     wr_en;
   logic     rd_en;

   assign idx   = bus.addr[REG_IDX_LSB +: REG_IDX_W];
   // status slot takes no writes
   assign wr_en = bus.en && bus.we && (idx != DMA_STATUS_IDX);
   assign rd_en = bus.en && !bus.we;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_DMA_REGS; i++)
         begin
            regs[i] <= '0;
         end
         // status comes up at its fixed value
         regs[DMA_STATUS_IDX] <= DMA_STATUS_WORD;
      end
      else if (wr_en)
      begin
         regs[idx] <= bus.din[WORD_W-1:0];
      end
   end

   // zero-extended readback, zero when not read
   assign bus.dout = rd_en ? {{(MI_DATA_W-WORD_W){1'b0}}, regs[idx]} : '0;

   // status never moves once out of reset
   a_status_const: assert property (@(posedge clk) disable iff (!rst_n)
      regs[DMA_STATUS_IDX] == DMA_STATUS_WORD);

endmodule

`default_nettype wire

// ==== hw/mmu_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmu_table (
   input  wire logic clk,
   input  wire logic rst_n,
   mi_bus_if.block   bus
);
   import mesh_cfg_pkg::*;

   mi_data_t table_q [NUM_MMU_ENTRIES];
   mmu_idx_t idx;
   logic     wr_en;
   logic     rd_en;

   // 64-bit entries, index from address bits 6:3
   assign idx   = bus.addr[MMU_IDX_LSB +: MMU_IDX_W];
   assign wr_en = bus.en && bus.we;
   assign rd_en = bus.en && !bus.we;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_MMU_ENTRIES; i++)
         begin
            table_q[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         // srcaddr half and data half both kept
         table_q[idx] <= bus.din;
      end
   end

   // whole entry back, high half ends up as response srcaddr
   assign bus.dout = rd_en ? table_q[idx] : '0;

endmodule

`default_nettype wire

// ==== hw/mesh_cfg_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mesh_cfg_decode #(
   parameter bit rx_side = 1'b0
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 access_in,
   input  wire mesh_cfg_pkg::packet_t packet_in,
   input  wire logic                 wait_in,
   mi_bus_if.decoder                 cfg_bus,
   mi_bus_if.decoder                 dma_bus,
   mi_bus_if.decoder                 mmu_bus,
   output logic                      access_out,
   output mesh_cfg_pkg::packet_t     packet_out
);
   import mesh_cfg_pkg::*;

   logic      req_write;
   datamode_t req_datamode;
   ctrlmode_t req_ctrlmode;
   addr_t     req_dstaddr;
   word_t     req_data;
   addr_t     req_srcaddr;

   logic      chip_match;
   logic      cfg_sel;
   logic      dma_sel;
   logic      mmu_sel;
   logic      blk_sel;
   logic      rd_sel;
   logic      fwd_sel;
   logic      out_fire;
   mi_data_t  readback;
   packet_t   resp_pkt;

   // unpack request fields
   assign req_write    = packet_in[WRITE_BIT];
   assign req_datamode = packet_in[DATAMODE_LSB +: DATAMODE_W];
   assign req_ctrlmode = packet_in[CTRLMODE_LSB +: CTRLMODE_W];
   assign req_dstaddr  = packet_in[DSTADDR_LSB +: ADDR_W];
   assign req_data     = packet_in[DATA_LSB +: WORD_W];
   assign req_srcaddr  = packet_in[SRCADDR_LSB +: ADDR_W];

   // this chip only
   assign chip_match = access_in && (req_dstaddr[CHIP_LSB +: 12] == CHIP_ID);

   // config, group F, subgroup 01x with side in bit 8
   assign cfg_sel = chip_match
                 && (req_dstaddr[GROUP_LSB +: 4] == GROUP_CFG)
                 && (req_dstaddr[CFG_SUB_LSB +: 2] == CFG_SUBGROUP)
                 && (req_dstaddr[CFG_SIDE_BIT] == rx_side);

   // dma shares group F, subgroup 5
   assign dma_sel = chip_match
                 && (req_dstaddr[GROUP_LSB +: 4] == GROUP_CFG)
                 && (req_dstaddr[DMA_SUB_LSB +: 3] == DMA_SUBGROUP)
                 && (req_dstaddr[DMA_SIDE_BIT] == rx_side);

   // mmu table, group E, side in bit 15
   assign mmu_sel = chip_match
                 && (req_dstaddr[GROUP_LSB +: 4] == GROUP_MMU)
                 && (req_dstaddr[MMU_SIDE_BIT] == rx_side);

   assign blk_sel = cfg_sel || dma_sel || mmu_sel;
   assign rd_sel  = blk_sel && !req_write;
   // our chip but no block hit, hand it on untouched
   assign fwd_sel = chip_match && !blk_sel;

   // same request info on every bus, only en differs
   assign cfg_bus.en   = cfg_sel;
   assign cfg_bus.we   = req_write;
   assign cfg_bus.addr = req_dstaddr[MI_ADDR_W-1:0];
   assign cfg_bus.din  = {req_srcaddr, req_data};

   assign dma_bus.en   = dma_sel;
   assign dma_bus.we   = req_write;
   assign dma_bus.addr = req_dstaddr[MI_ADDR_W-1:0];
   assign dma_bus.din  = {req_srcaddr, req_data};

   assign mmu_bus.en   = mmu_sel;
   assign mmu_bus.we   = req_write;
   assign mmu_bus.addr = req_dstaddr[MI_ADDR_W-1:0];
   assign mmu_bus.din  = {req_srcaddr, req_data};

   // idle blocks drive zero so a plain OR works
   assign readback = cfg_bus.dout | dma_bus.dout | mmu_bus.dout;

   // wait drops reads and forwards, writes go ahead
   assign out_fire = (rd_sel || fwd_sel) && !wait_in;

   // read response goes back to the requester
   always_comb
   begin
      resp_pkt = packet_in;
      if (rd_sel)
      begin
         resp_pkt                                 = '0;
         resp_pkt[WRITE_BIT]                      = 1'b1;
         resp_pkt[DATAMODE_LSB +: DATAMODE_W]     = req_datamode;
         resp_pkt[CTRLMODE_LSB +: CTRLMODE_W]     = req_ctrlmode;
         resp_pkt[RSVD_BIT]                       = 1'b0;
         resp_pkt[DSTADDR_LSB +: ADDR_W]          = req_srcaddr;
         resp_pkt[DATA_LSB +: WORD_W]             = readback[WORD_W-1:0];
         resp_pkt[SRCADDR_LSB +: ADDR_W]          = readback[MI_DATA_W-1:WORD_W];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         access_out <= 1'b0;
      end
      else
      begin
         access_out <= out_fire;
      end
   end

   // packet holds until the next output
   always_ff @(posedge clk)
   begin
      if (out_fire)
      begin
         packet_out <= resp_pkt;
      end
   end

   // address map regions must not overlap
   a_one_block: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({cfg_bus.en, dma_bus.en, mmu_bus.en}));

   // one pulse per request, never stretched
   a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      access_out && !access_in |=> !access_out);

endmodule

`default_nettype wire

// ==== hw/mesh_cfg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mesh_cfg_top (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 access_in,
   input  wire mesh_cfg_pkg::packet_t packet_in,
   input  wire logic                 wait_in,
   output logic                      access_out,
   output mesh_cfg_pkg::packet_t     packet_out
);

   // one bus per register block
   mi_bus_if cfg_bus ();
   mi_bus_if dma_bus ();
   mi_bus_if mmu_bus ();

   // tx side instance
   mesh_cfg_decode #(
      .rx_side (1'b0)
   ) u_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .cfg_bus    (cfg_bus.decoder),
      .dma_bus    (dma_bus.decoder),
      .mmu_bus    (mmu_bus.decoder),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   cfg_regs u_cfg_regs (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (cfg_bus.block)
   );

   dma_regs u_dma_regs (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (dma_bus.block)
   );

   // translation entries only, no lookup path
   mmu_table u_mmu_table (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mmu_bus.block)
   );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release on a falling edge, away from the sampling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verif/mesh_cfg_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mesh_cfg_tb;
   import mesh_cfg_pkg::*;

   localparam int RESET_CYCLES = 4;
   // request count over all tests below
   localparam int NUM_REQS   = 115;
   localparam int MAX_CYCLES = NUM_REQS * 2 + RESET_CYCLES + 20;

   logic    clk;
   logic    rst_n;
   logic    access_in;
   packet_t packet_in;
   logic    wait_in;
   logic    access_out;
   packet_t packet_out;

   integer seed = 32'h600d_e773;
   int     errors = 0;
   int     cycles = 0;

   // shadow copy of the three blocks
   word_t       cfg_shadow [8];
   word_t       dma_shadow [8];
   logic [63:0] mmu_shadow [16];

   // expectation for the request driven now, and for the one sampled last edge
   bit      cur_valid = 1'b0;
   packet_t cur_pkt;
   string   cur_name = "";
   bit      pend_valid = 1'b0;
   packet_t pend_pkt;
   string   pend_name = "";

   tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mesh_cfg_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   function automatic addr_t cfg_addr(input logic [2:0] i);
      return {12'h810, 4'hF, 5'b0, 2'b01, 1'b0, 3'b0, i, 2'b00};
   endfunction

   function automatic addr_t dma_addr(input logic [2:0] i);
      return {12'h810, 4'hF, 5'b0, 3'b101, 2'b00, 1'b0, i, 2'b00};
   endfunction

   function automatic addr_t mmu_addr(input logic [3:0] i);
      return {12'h810, 4'hE, 1'b0, 8'b0, i, 3'b000};
   endfunction

   // random modes, data and srcaddr; reserved bit stays zero
   function automatic packet_t rand_pkt(input logic wr, input addr_t dst);
      packet_t p;
      word_t   rnd;
      rnd = $random(seed);
      p = '0;
      p[0] = wr;
      p[6:1] = rnd[5:0];
      p[39:8] = dst;
      p[71:40] = $random(seed);
      p[103:72] = $random(seed);
      return p;
   endfunction

   // address map plus shadow update, returns 1 when an output is due
   function automatic bit model_request(input packet_t pkt, input logic wait_lvl,
                                        output packet_t exp_pkt);
      addr_t       dst;
      addr_t       src;
      word_t       data;
      logic [63:0] rd;
      logic [2:0]  ridx;
      logic [3:0]  midx;
      bit          hit;
      dst = pkt[39:8];
      data = pkt[71:40];
      src = pkt[103:72];
      ridx = dst[4:2];
      midx = dst[6:3];
      exp_pkt = pkt;
      hit = 1'b1;
      rd = '0;
      // other chips are ignored outright
      if (dst[31:20] != 12'h810)
         return 1'b0;
      if (dst[19:16] == 4'hF && dst[10:9] == 2'b01 && !dst[8])
      begin
         if (pkt[0])
            cfg_shadow[ridx] = data;
         rd = {32'h0, cfg_shadow[ridx]};
      end
      else if (dst[19:16] == 4'hF && dst[10:8] == 3'b101 && !dst[5])
      begin
         // status slot keeps its constant
         if (pkt[0] && ridx != 3'd7)
            dma_shadow[ridx] = data;
         rd = {32'h0, dma_shadow[ridx]};
      end
      else if (dst[19:16] == 4'hE && !dst[15])
      begin
         if (pkt[0])
            mmu_shadow[midx] = {src, data};
         rd = mmu_shadow[midx];
      end
      else
         hit = 1'b0;
      // writes land even while wait is high
      if (wait_lvl)
         return 1'b0;
      if (!hit)
         return 1'b1;
      if (pkt[0])
         return 1'b0;
      exp_pkt = '0;
      exp_pkt[0] = 1'b1;
      exp_pkt[6:1] = pkt[6:1];
      exp_pkt[39:8] = src;
      exp_pkt[71:40] = rd[31:0];
      exp_pkt[103:72] = rd[63:32];
      return 1'b1;
   endfunction

   task automatic compare_packet(input string name, input packet_t expected,
                                 input packet_t actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic send_req(input string name, input packet_t pkt, input logic wait_lvl);
      packet_t exp_pkt;
      bit      exp_out;
      @(negedge clk);
      exp_out = model_request(pkt, wait_lvl, exp_pkt);
      access_in = 1'b1;
      packet_in = pkt;
      wait_in = wait_lvl;
      cur_name = name;
      cur_pkt = exp_pkt;
      cur_valid = exp_out;
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      access_in = 1'b0;
      wait_in = 1'b0;
      cur_valid = 1'b0;
   endtask

   task automatic send_one(input string name, input packet_t pkt, input logic wait_lvl);
      send_req(name, pkt, wait_lvl);
      idle_cycle();
   endtask

   // response due one clock after the request edge
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (pend_valid && !access_out)
         begin
            $display("no response came back for %s", pend_name);
            errors++;
         end
         else if (pend_valid)
            compare_packet(pend_name, pend_pkt, packet_out);
         else if (access_out)
         begin
            $display("access_out went high with no response due, after %s", pend_name);
            errors++;
         end
         pend_valid = cur_valid;
         pend_pkt = cur_pkt;
         pend_name = cur_name;
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("run stopped by timeout after %0d cycles, errors %0d", cycles, errors);
         $display("test failed");
         $finish;
      end
   end

   initial
   begin
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      for (int i = 0; i < 8; i++)
      begin
         cfg_shadow[i] = CFG_RESET_VALUES[i];
         dma_shadow[i] = '0;
      end
      dma_shadow[7] = DMA_STATUS_WORD;
      for (int i = 0; i < 16; i++)
         mmu_shadow[i] = '0;
      @(posedge rst_n);

      // reset contents
      for (int i = 0; i < 8; i++)
         send_one("reset_cfg", rand_pkt(1'b0, cfg_addr(i[2:0])), 1'b0);
      for (int i = 0; i < 8; i++)
         send_one("reset_dma", rand_pkt(1'b0, dma_addr(i[2:0])), 1'b0);
      for (int i = 0; i < 16; i++)
         send_one("reset_mmu", rand_pkt(1'b0, mmu_addr(i[3:0])), 1'b0);

      // random writes then reads, status slot included
      for (int i = 0; i < 8; i++)
      begin
         send_one("rand_cfg_wr", rand_pkt(1'b1, cfg_addr(i[2:0])), 1'b0);
         send_one("rand_dma_wr", rand_pkt(1'b1, dma_addr(i[2:0])), 1'b0);
      end
      for (int i = 0; i < 8; i++)
      begin
         send_one("rand_cfg_rd", rand_pkt(1'b0, cfg_addr(i[2:0])), 1'b0);
         send_one("rand_dma_rd", rand_pkt(1'b0, dma_addr(i[2:0])), 1'b0);
      end

      // mmu keeps both halves
      for (int i = 0; i < 16; i++)
         send_one("mmu_wr", rand_pkt(1'b1, mmu_addr(i[3:0])), 1'b0);
      for (int i = 0; i < 16; i++)
         send_one("mmu_rd", rand_pkt(1'b0, mmu_addr(i[3:0])), 1'b0);

      // forwards: no group, then each block with the other side bit
      send_one("fwd_no_group", rand_pkt(1'b0, 32'h8100_1234), 1'b0);
      send_one("fwd_cfg_side", rand_pkt(1'b0, 32'h810F_0300), 1'b0);
      send_one("fwd_dma_side", rand_pkt(1'b1, 32'h810F_0520), 1'b0);
      send_one("fwd_mmu_side", rand_pkt(1'b0, 32'h810E_8000), 1'b0);
      // another chip touches nothing
      send_one("other_chip_wr", rand_pkt(1'b1, 32'h820F_0200), 1'b0);
      send_one("other_chip_rd", rand_pkt(1'b0, 32'h820F_0200), 1'b0);
      send_one("other_chip_chk", rand_pkt(1'b0, cfg_addr(3'd0)), 1'b0);

      // wait high drops reads and forwards only
      send_one("wait_wr", rand_pkt(1'b1, cfg_addr(3'd3)), 1'b1);
      send_one("wait_rd", rand_pkt(1'b0, cfg_addr(3'd3)), 1'b1);
      send_one("wait_fwd", rand_pkt(1'b0, 32'h8100_0040), 1'b1);
      send_one("wait_chk", rand_pkt(1'b0, cfg_addr(3'd3)), 1'b0);

      // back-to-back reads, one per cycle
      for (int i = 0; i < 8; i++)
         send_req("b2b_rd", rand_pkt(1'b0, cfg_addr(i[2:0])), 1'b0);
      idle_cycle();
      repeat (3) @(negedge clk);

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/mesh_cfg_pkg.sv
hw/mi_bus_if.sv
hw/cfg_regs.sv
hw/dma_regs.sv
hw/mmu_table.sv
hw/mesh_cfg_decode.sv
hw/mesh_cfg_top.sv
verif/tb_clock_gen.sv
verif/mesh_cfg_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= mesh_cfg_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
